/* soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

    // widths with a meaning on the bus
    typedef logic [31:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [31:0] word_t;
    typedef logic [2:0]  prio_t;

    // access size, shared by loads and stores (sb/sh/sw/sd use lb/lh/lw/ld)
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        ld  = 3'b011,
        lbu = 3'b100,
        lhu = 3'b101,
        lwu = 3'b110
    } ls_type_t;

    typedef enum logic [1:0] {
        tgt_none,
        tgt_ram,
        tgt_plic
    } target_t;

    // on-chip ram window
    localparam addr_t RAM_BASE  = 32'h8000_0000;
    localparam int    RAM_WORDS = 1024;
    localparam int    RAM_IDX_W = $clog2(RAM_WORDS);
    localparam addr_t RAM_SPAN  = addr_t'(RAM_WORDS * 4);

    typedef logic [RAM_IDX_W-1:0] ram_idx_t;

    // interrupt controller window and register offsets
    localparam addr_t PLIC_BASE              = 32'h0C00_0000;
    localparam addr_t PLIC_SPAN              = 32'h0040_0000;
    localparam int    PLIC_SOURCES           = 6;
    localparam int    PLIC_CONTEXTS          = 2;
    localparam addr_t PLIC_PENDING_OFS       = 32'h0000_1000;
    localparam addr_t PLIC_ENABLE_OFS        = 32'h0000_2000;
    localparam addr_t PLIC_CTX_ENABLE_STRIDE = 32'h0000_0080;
    localparam addr_t PLIC_THRESHOLD_OFS     = 32'h0020_0000;
    localparam addr_t PLIC_CLAIM_OFS         = 32'h0020_0004;
    localparam addr_t PLIC_CTX_STRIDE        = 32'h0000_1000;

    // request as held by the master
    typedef struct packed {
        addr_t    addr;
        data_t    wdata;
        logic     write;
        ls_type_t ls_type;
    } bus_req_t;

    // decoded request, offset is relative to the target window
    typedef struct packed {
        target_t  target;
        addr_t    offset;
        data_t    wdata;
        logic     write;
        ls_type_t ls_type;
    } stage_op_t;

    typedef struct packed {
        logic  done;
        data_t rdata;
    } target_rsp_t;

endpackage

`default_nettype wire

/* bus_decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_decode_stage import soc_bus_pkg::*; (
    input  wire       CLOCK_50,
    input  wire       KEY0,
    input  wire       req,
    input  wire       bus_req_t bus_req,
    input  wire       txn_release,
    output logic      op_valid,
    output stage_op_t op
);

    logic      busy;
    logic      cap_valid;
    bus_req_t  req_q;
    stage_op_t dec_op;

    // one transaction in flight, held until the response stage releases it
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            busy      <= 1'b0;
            cap_valid <= 1'b0;
            op_valid  <= 1'b0;
        end else begin
            cap_valid <= 1'b0;
            op_valid  <= cap_valid;
            if (req && !busy) begin
                busy      <= 1'b1;
                cap_valid <= 1'b1;
            end else if (txn_release) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (req && !busy) begin
            req_q <= bus_req;
        end
        if (cap_valid) begin
            op <= dec_op;
        end
    end

    // address windows
    always_comb begin
        dec_op.target  = tgt_none;
        dec_op.offset  = '0;
        dec_op.wdata   = req_q.wdata;
        dec_op.write   = req_q.write;
        dec_op.ls_type = req_q.ls_type;
        if (req_q.addr >= RAM_BASE && req_q.addr < RAM_BASE + RAM_SPAN) begin
            dec_op.target = tgt_ram;
            dec_op.offset = req_q.addr - RAM_BASE;
        end else if (req_q.addr >= PLIC_BASE && req_q.addr < PLIC_BASE + PLIC_SPAN) begin
            dec_op.target = tgt_plic;
            dec_op.offset = req_q.addr - PLIC_BASE;
        end
    end

    // master must not change the request while it is being served
    bus_req_held: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        busy && req && $past(req) |-> $stable(bus_req)
    );

endmodule

`default_nettype wire

/* ram_target.sv */
`timescale 1ns/1ns
`default_nettype none

module ram_target import soc_bus_pkg::*; (
    input  wire         CLOCK_50,
    input  wire         KEY0,
    input  wire         op_valid,
    input  wire         stage_op_t op,
    output target_rsp_t rsp
);

    typedef enum logic {
        rs_idle,
        rs_second
    } ram_state_t;

    ram_state_t state;
    word_t      mem [RAM_WORDS];
    logic       hit;
    ram_idx_t   idx;
    ram_idx_t   next_idx;
    word_t      hi_word;
    logic       write_q;
    logic       rsp_done;
    data_t      rdata_q;
    data_t      load_value;

    assign hit = op_valid && op.target == tgt_ram;
    // word index wraps inside the ram
    assign idx = op.offset[RAM_IDX_W+1:2];

    // ld and sd take a second cycle for the upper word
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state    <= rs_idle;
            rsp_done <= 1'b0;
        end else begin
            rsp_done <= 1'b0;
            case (state)
                rs_idle: begin
                    if (hit && op.ls_type == ld) begin
                        state <= rs_second;
                    end else if (hit) begin
                        rsp_done <= 1'b1;
                    end
                end
                rs_second: begin
                    state    <= rs_idle;
                    rsp_done <= 1'b1;
                end
                default: state <= rs_idle;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (hit) begin
            next_idx <= idx + 1'b1;
            hi_word  <= op.wdata[63:32];
            write_q  <= op.write;
            if (op.write) begin
                rdata_q <= '0;
                // only the size bits matter for stores
                case (op.ls_type[1:0])
                    2'b00:   mem[idx][8*op.offset[1:0] +: 8] <= op.wdata[7:0];
                    2'b01:   mem[idx][16*op.offset[1] +: 16] <= op.wdata[15:0];
                    default: mem[idx] <= op.wdata[31:0];
                endcase
            end else begin
                rdata_q <= load_value;
            end
        end else if (state == rs_second) begin
            if (write_q) begin
                mem[next_idx] <= hi_word;
            end else begin
                rdata_q[63:32] <= mem[next_idx];
            end
        end
    end

    // lane select and extension
    always_comb begin
        word_t          word;
        logic [7:0]     byte_v;
        logic [15:0]    half_v;
        word   = mem[idx];
        byte_v = word[8*op.offset[1:0] +: 8];
        half_v = word[16*op.offset[1] +: 16];
        case (op.ls_type)
            lb:      load_value = {{56{byte_v[7]}}, byte_v};
            lh:      load_value = {{48{half_v[15]}}, half_v};
            lw:      load_value = {{32{word[31]}}, word};
            ld:      load_value = {32'b0, word};
            lbu:     load_value = {56'b0, byte_v};
            lhu:     load_value = {48'b0, half_v};
            lwu:     load_value = {32'b0, word};
            default: load_value = '0;
        endcase
    end

    assign rsp = '{done: rsp_done, rdata: rdata_q};

    // decode passes the offset straight from the master, so alignment is its duty
    ram_access_aligned: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        hit |-> ((op.ls_type inside {lh, lhu}) -> !op.offset[0])
             && ((op.ls_type inside {lw, lwu, ld}) -> op.offset[1:0] == 2'b00)
    );

endmodule

`default_nettype wire

/* plic_target.sv */
`timescale 1ns/1ns
`default_nettype none

module plic_target import soc_bus_pkg::*; (
    input  wire         CLOCK_50,
    input  wire         KEY0,
    input  wire         op_valid,
    input  wire         stage_op_t op,
    input  wire         ext_irq,
    output target_rsp_t rsp,
    output logic        meip,
    output logic        seip
);

    prio_t      prio [PLIC_SOURCES];
    word_t      pending;
    word_t      enable [PLIC_CONTEXTS];
    prio_t      threshold [PLIC_CONTEXTS];
    word_t      claim_id [PLIC_CONTEXTS];
    logic       ext_q;
    logic       ext_rise;
    logic       hit;
    logic       prio_sel;
    logic [9:0] prio_id;
    logic       pend_sel;
    logic       en_sel [PLIC_CONTEXTS];
    logic       thr_sel [PLIC_CONTEXTS];
    logic       clm_sel [PLIC_CONTEXTS];
    logic       rsp_done;
    data_t      rd_val;
    data_t      rdata_q;

    assign hit      = op_valid && op.target == tgt_plic;
    assign ext_rise = ext_irq && !ext_q;

    // only source 1 is wired, priority and threshold do not gate it
    always_comb begin
        for (int c = 0; c < PLIC_CONTEXTS; c++) begin
            claim_id[c] = (pending[1] && enable[c][1]) ? word_t'(1) : word_t'(0);
        end
    end

    assign meip = claim_id[0] != '0;
    assign seip = claim_id[1] != '0;

    // register select
    always_comb begin
        prio_sel = op.offset < PLIC_PENDING_OFS;
        prio_id  = op.offset[11:2];
        pend_sel = op.offset == PLIC_PENDING_OFS;
        rd_val   = '0;
        for (int c = 0; c < PLIC_CONTEXTS; c++) begin
            en_sel[c]  = op.offset == PLIC_ENABLE_OFS + addr_t'(c) * PLIC_CTX_ENABLE_STRIDE;
            thr_sel[c] = op.offset == PLIC_THRESHOLD_OFS + addr_t'(c) * PLIC_CTX_STRIDE;
            clm_sel[c] = op.offset == PLIC_CLAIM_OFS + addr_t'(c) * PLIC_CTX_STRIDE;
        end
        if (prio_sel && prio_id < PLIC_SOURCES) begin
            rd_val = data_t'(prio[prio_id[2:0]]);
        end else if (pend_sel) begin
            rd_val = data_t'(pending);
        end
        for (int c = 0; c < PLIC_CONTEXTS; c++) begin
            if (en_sel[c]) rd_val = data_t'(enable[c]);
            if (thr_sel[c]) rd_val = data_t'(threshold[c]);
            if (clm_sel[c]) rd_val = data_t'(claim_id[c]);
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rsp_done <= 1'b0;
            ext_q    <= 1'b0;
            pending  <= '0;
            for (int i = 0; i < PLIC_SOURCES; i++) begin
                prio[i] <= '0;
            end
            for (int c = 0; c < PLIC_CONTEXTS; c++) begin
                enable[c]    <= '0;
                threshold[c] <= '0;
            end
        end else begin
            rsp_done <= hit;
            ext_q    <= ext_irq;
            if (hit && op.write) begin
                if (prio_sel && prio_id < PLIC_SOURCES) begin
                    prio[prio_id[2:0]] <= op.wdata[2:0];
                end
                for (int c = 0; c < PLIC_CONTEXTS; c++) begin
                    if (en_sel[c]) enable[c] <= op.wdata[31:0];
                    if (thr_sel[c]) threshold[c] <= op.wdata[2:0];
                end
            end else if (hit) begin
                // a claim read retires the pending source
                for (int c = 0; c < PLIC_CONTEXTS; c++) begin
                    if (clm_sel[c] && claim_id[c] != '0) pending[claim_id[c][4:0]] <= 1'b0;
                end
            end
            // a fresh edge wins over a claim in the same cycle
            if (ext_rise) pending[1] <= 1'b1;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (hit) begin
            rdata_q <= op.write ? '0 : rd_val;
        end
    end

    assign rsp = '{done: rsp_done, rdata: rdata_q};

    // meip can only come up with source 1 pending, set by an edge or left over
    meip_from_pending: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        $rose(meip) |-> pending[1] && ($past(ext_rise) || $past(pending[1]))
    );

endmodule

`default_nettype wire

/* bus_response_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_response_stage import soc_bus_pkg::*; (
    input  wire   CLOCK_50,
    input  wire   KEY0,
    input  wire   req,
    input  wire   op_valid,
    input  wire   stage_op_t op,
    input  wire   target_rsp_t ram_rsp,
    input  wire   target_rsp_t plic_rsp,
    output logic  ack,
    output data_t rdata,
    output logic  txn_release
);

    typedef enum logic {
        st_idle,
        st_acked
    } rsp_state_t;

    rsp_state_t state;
    logic       none_hit;
    logic       finish;
    data_t      sel_data;

    // nothing answers an unmapped address, so finish it here
    assign none_hit = op_valid && op.target == tgt_none;
    assign finish   = ram_rsp.done || plic_rsp.done || none_hit;

    always_comb begin
        if (ram_rsp.done) begin
            sel_data = ram_rsp.rdata;
        end else if (plic_rsp.done) begin
            sel_data = plic_rsp.rdata;
        end else begin
            sel_data = '0;
        end
    end

    // four-phase return, ack held until the master lets go of req
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state       <= st_idle;
            txn_release <= 1'b0;
        end else begin
            txn_release <= 1'b0;
            case (state)
                st_idle: begin
                    if (finish) state <= st_acked;
                end
                st_acked: begin
                    if (!req) begin
                        state       <= st_idle;
                        txn_release <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (state == st_idle && finish) begin
            rdata <= sel_data;
        end
    end

    assign ack = state == st_acked;

    // the done that ends a request comes from the target it was decoded to
    ack_after_done: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        $rose(ack) |-> $past(none_hit)
            || $past(ram_rsp.done && op.target == tgt_ram)
            || $past(plic_rsp.done && op.target == tgt_plic)
    );

endmodule

`default_nettype wire

/* soc_bus_top.sv */
`timescale 1ns/1ns
`default_nettype none

module soc_bus_top import soc_bus_pkg::*; (
    input  wire   CLOCK_50,
    input  wire   KEY0,
    input  wire   req,
    input  wire   bus_req_t bus_req,
    input  wire   ext_irq,
    output logic  ack,
    output data_t rdata,
    output logic  meip,
    output logic  seip
);

    logic        op_valid;
    stage_op_t   op;
    target_rsp_t ram_rsp;
    target_rsp_t plic_rsp;
    logic        txn_release;

    bus_decode_stage i_bus_decode_stage (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .req         (req),
        .bus_req     (bus_req),
        .txn_release (txn_release),
        .op_valid    (op_valid),
        .op          (op)
    );

    ram_target i_ram_target (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .op_valid (op_valid),
        .op       (op),
        .rsp      (ram_rsp)
    );

    plic_target i_plic_target (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .op_valid (op_valid),
        .op       (op),
        .ext_irq  (ext_irq),
        .rsp      (plic_rsp),
        .meip     (meip),
        .seip     (seip)
    );

    bus_response_stage i_bus_response_stage (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .req         (req),
        .op_valid    (op_valid),
        .op          (op),
        .ram_rsp     (ram_rsp),
        .plic_rsp    (plic_rsp),
        .ack         (ack),
        .rdata       (rdata),
        .txn_release (txn_release)
    );

endmodule

`default_nettype wire

/* tb_soc_bus.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_soc_bus import soc_bus_pkg::*; ();

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 16;
    localparam int ACK_TIMEOUT     = 20;
    localparam int RESET_READS     = PLIC_SOURCES + 5;
    localparam int FILL_OPS        = RAM_WORDS / 2;
    localparam int RANDOM_OPS      = 400;
    localparam int DWORD_ROUNDS    = 10;
    localparam int UNMAPPED_ROUNDS = 16;
    localparam int REG_ROUNDS      = 20;
    localparam int IRQ_ROUNDS      = 24;
    localparam int TOTAL_TXN       = 2 * RESET_READS + FILL_OPS + RANDOM_OPS
                                   + 3 * DWORD_ROUNDS + 4 * UNMAPPED_ROUNDS + 6 * REG_ROUNDS
                                   + 6 * IRQ_ROUNDS;
    localparam int WATCHDOG_CYCLES = TOTAL_TXN * 20 + 1000;

    logic     CLOCK_50 = 1'b0;
    logic     KEY0;
    logic     req;
    bus_req_t bus_req;
    logic     ext_irq;
    logic     ack;
    data_t    rdata;
    logic     meip;
    logic     seip;

    // reference copies of ram and controller state
    word_t ram_model [RAM_WORDS];
    prio_t prio_model [PLIC_SOURCES];
    word_t pending_model;
    word_t enable_model [PLIC_CONTEXTS];
    prio_t threshold_model [PLIC_CONTEXTS];

    soc_bus_top i_soc_bus_top (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .req      (req),
        .bus_req  (bus_req),
        .ext_irq  (ext_irq),
        .ack      (ack),
        .rdata    (rdata),
        .meip     (meip),
        .seip     (seip)
    );

    always #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input data_t expected, input data_t actual);
        assert (actual === expected) else begin
            abort_run($sformatf("FAIL time=%0t %s expected=%h actual=%h",
                                $time, name, expected, actual));
        end
    endtask

    // one four-phase transaction, req held a random number of cycles after ack
    task automatic bus_xfer(input addr_t addr, input data_t wdata, input logic write,
                            input ls_type_t ls, output data_t rd);
        int unsigned cycles;
        int unsigned hold;
        @(negedge CLOCK_50);
        check_value("ack (idle before req)", '0, data_t'(ack));
        bus_req.addr    = addr;
        bus_req.wdata   = wdata;
        bus_req.write   = write;
        bus_req.ls_type = ls;
        req = 1'b1;
        cycles = 0;
        while (!ack) begin
            @(negedge CLOCK_50);
            cycles++;
            if (cycles > ACK_TIMEOUT) begin
                abort_run($sformatf("no ack within %0d cycles for address %h", ACK_TIMEOUT, addr));
            end
        end
        rd = rdata;
        hold = $urandom_range(0, 5);
        repeat (hold) begin
            @(negedge CLOCK_50);
            check_value("ack (req still high)", 64'd1, data_t'(ack));
            check_value("rdata (held)", rd, rdata);
        end
        req = 1'b0;
        cycles = 0;
        while (ack) begin
            @(negedge CLOCK_50);
            cycles++;
            if (cycles > 4) begin
                abort_run("ack stayed high after req was dropped");
            end
        end
        // no second ack without a new req
        @(negedge CLOCK_50);
        check_value("ack (no new req)", '0, data_t'(ack));
    endtask

    function automatic word_t fill_word(input int unsigned idx);
        addr_t addr;
        addr = RAM_BASE + addr_t'(idx * 4);
        return (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    function automatic data_t expect_load(input ls_type_t ls, input int unsigned idx,
                                          input logic [1:0] lane);
        word_t       w;
        logic [7:0]  b;
        logic [15:0] h;
        data_t       result;
        w = ram_model[idx % RAM_WORDS];
        b = w[8*lane +: 8];
        h = w[16*lane[1] +: 16];
        case (ls)
            lb:      result = {{56{b[7]}}, b};
            lh:      result = {{48{h[15]}}, h};
            lw:      result = {{32{w[31]}}, w};
            ld:      result = {ram_model[(idx + 1) % RAM_WORDS], w};
            lbu:     result = {56'b0, b};
            lhu:     result = {48'b0, h};
            lwu:     result = {32'b0, w};
            default: result = '0;
        endcase
        return result;
    endfunction

    function automatic void model_store(input ls_type_t ls, input int unsigned idx,
                                        input logic [1:0] lane, input data_t wd);
        case (ls)
            lb:      ram_model[idx][8*lane +: 8] = wd[7:0];
            lh:      ram_model[idx][16*lane[1] +: 16] = wd[15:0];
            lw:      ram_model[idx] = wd[31:0];
            default: begin
                ram_model[idx] = wd[31:0];
                ram_model[(idx + 1) % RAM_WORDS] = wd[63:32];
            end
        endcase
    endfunction

    task automatic ram_op(input logic write, input ls_type_t ls, input int unsigned idx,
                          input logic [1:0] lane, input data_t wd);
        addr_t addr;
        data_t exp;
        data_t rd;
        addr = RAM_BASE + addr_t'(idx * 4) + addr_t'(lane);
        exp = write ? data_t'(0) : expect_load(ls, idx, lane);
        bus_xfer(addr, wd, write, ls, rd);
        if (write) model_store(ls, idx, lane, wd);
        check_value($sformatf("rdata @%h", addr), exp, rd);
    endtask

    task automatic random_ram_op();
        logic        write;
        ls_type_t    ls;
        int unsigned idx;
        logic [1:0]  lane;
        write = $urandom_range(0, 1);
        ls = write ? ls_type_t'($urandom_range(0, 3)) : ls_type_t'($urandom_range(0, 6));
        // mostly a small hot region so loads see earlier stores
        if ($urandom_range(0, 3) == 0) idx = $urandom_range(0, RAM_WORDS - 1);
        else idx = $urandom_range(0, 31);
        lane = $urandom_range(0, 3);
        case (ls)
            lh, lhu: lane[0] = 1'b0;
            lw, lwu: lane = 2'b00;
            ld: begin
                lane = 2'b00;
                idx = idx & ~32'd1;
            end
            default: ;
        endcase
        ram_op(write, ls, idx, lane, {$urandom, $urandom});
    endtask

    task automatic plic_write(input addr_t ofs, input data_t value);
        data_t rd;
        bus_xfer(PLIC_BASE + ofs, value, 1'b1, lw, rd);
        check_value("rdata (controller store)", '0, rd);
    endtask

    task automatic plic_read(input string name, input addr_t ofs, input data_t exp);
        data_t rd;
        bus_xfer(PLIC_BASE + ofs, '0, 1'b0, lw, rd);
        check_value(name, exp, rd);
    endtask

    function automatic addr_t enable_ofs(input int unsigned ctx);
        return PLIC_ENABLE_OFS + addr_t'(ctx) * PLIC_CTX_ENABLE_STRIDE;
    endfunction

    function automatic addr_t threshold_ofs(input int unsigned ctx);
        return PLIC_THRESHOLD_OFS + addr_t'(ctx) * PLIC_CTX_STRIDE;
    endfunction

    function automatic addr_t claim_ofs(input int unsigned ctx);
        return PLIC_CLAIM_OFS + addr_t'(ctx) * PLIC_CTX_STRIDE;
    endfunction

    task automatic check_irq_lines();
        check_value("meip", data_t'(pending_model[1] && enable_model[0][1]), data_t'(meip));
        check_value("seip", data_t'(pending_model[1] && enable_model[1][1]), data_t'(seip));
    endtask

    task automatic check_plic_state();
        for (int i = 0; i < PLIC_SOURCES; i++) begin
            plic_read($sformatf("priority[%0d]", i), addr_t'(4 * i), data_t'(prio_model[i]));
        end
        plic_read("pending", PLIC_PENDING_OFS, data_t'(pending_model));
        for (int c = 0; c < PLIC_CONTEXTS; c++) begin
            plic_read($sformatf("enable[%0d]", c), enable_ofs(c), data_t'(enable_model[c]));
            plic_read($sformatf("threshold[%0d]", c), threshold_ofs(c),
                      data_t'(threshold_model[c]));
        end
    endtask

    task automatic dword_round();
        int unsigned idx;
        data_t       wd;
        data_t       rd;
        idx = $urandom_range(0, RAM_WORDS - 1) & ~32'd1;
        wd = {$urandom, $urandom};
        ram_op(1'b1, ld, idx, 2'b00, wd);
        bus_xfer(RAM_BASE + addr_t'(idx * 4), '0, 1'b0, lw, rd);
        check_value("rdata (low word)", {{32{wd[31]}}, wd[31:0]}, rd);
        bus_xfer(RAM_BASE + addr_t'(idx * 4 + 4), '0, 1'b0, lw, rd);
        check_value("rdata (high word)", {{32{wd[63]}}, wd[63:32]}, rd);
    endtask

    task automatic unmapped_round();
        addr_t       addr;
        data_t       rd;
        int unsigned idx;
        // either far from both windows or just past the end of ram
        if ($urandom_range(0, 1)) addr = 32'h1000_0000 | ($urandom & 32'h3fff_fff8);
        else addr = RAM_BASE + RAM_SPAN + ($urandom & 32'h000f_fff8);
        bus_xfer(addr, '0, 1'b0, ld, rd);
        check_value("rdata (unmapped load)", '0, rd);
        bus_xfer(addr, {$urandom, $urandom}, 1'b1, ld, rd);
        check_value("rdata (unmapped store)", '0, rd);
        idx = ((addr - RAM_BASE) >> 2) % RAM_WORDS;
        ram_op(1'b0, ld, idx & ~32'd1, 2'b00, '0);
        plic_read("enable[0]", enable_ofs(0), data_t'(enable_model[0]));
    endtask

    task automatic register_round();
        int unsigned id;
        int unsigned ctx;
        word_t       value;
        data_t       exp;
        id = $urandom_range(0, 11);
        value = $urandom;
        plic_write(addr_t'(4 * id), {$urandom, value});
        exp = '0;
        if (id < PLIC_SOURCES) begin
            prio_model[id] = value[2:0];
            exp = data_t'(prio_model[id]);
        end
        plic_read($sformatf("priority[%0d]", id), addr_t'(4 * id), exp);
        ctx = $urandom_range(0, PLIC_CONTEXTS - 1);
        enable_model[ctx] = $urandom;
        plic_write(enable_ofs(ctx), {$urandom, enable_model[ctx]});
        plic_read($sformatf("enable[%0d]", ctx), enable_ofs(ctx), data_t'(enable_model[ctx]));
        value = $urandom;
        threshold_model[ctx] = value[2:0];
        plic_write(threshold_ofs(ctx), {$urandom, value});
        plic_read($sformatf("threshold[%0d]", ctx), threshold_ofs(ctx),
                  data_t'(threshold_model[ctx]));
    endtask

    task automatic irq_round();
        int unsigned ctx;
        data_t       exp;
        for (int c = 0; c < PLIC_CONTEXTS; c++) begin
            enable_model[c] = $urandom;
            plic_write(enable_ofs(c), data_t'(enable_model[c]));
        end
        if ($urandom_range(0, 3) != 0) begin
            @(negedge CLOCK_50);
            ext_irq = 1'b1;
            @(negedge CLOCK_50);
            ext_irq = 1'b0;
            pending_model[1] = 1'b1;
        end
        check_irq_lines();
        plic_read("pending", PLIC_PENDING_OFS, data_t'(pending_model));
        ctx = $urandom_range(0, PLIC_CONTEXTS - 1);
        // claim writes have no effect
        plic_write(claim_ofs(ctx), {$urandom, $urandom});
        check_irq_lines();
        exp = data_t'(pending_model[1] && enable_model[ctx][1]);
        plic_read($sformatf("claim[%0d]", ctx), claim_ofs(ctx), exp);
        if (exp == 64'd1) pending_model[1] = 1'b0;
        check_irq_lines();
        plic_read("pending (after claim)", PLIC_PENDING_OFS, data_t'(pending_model));
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run($sformatf("timeout, run did not end within %0d clock cycles", WATCHDOG_CYCLES));
    end

    initial begin
        void'($urandom(32'h97e33767));
        KEY0    = 1'b0;
        req     = 1'b0;
        ext_irq = 1'b0;
        bus_req = '0;
        pending_model = '0;
        for (int i = 0; i < PLIC_SOURCES; i++) prio_model[i] = '0;
        for (int c = 0; c < PLIC_CONTEXTS; c++) begin
            enable_model[c]    = '0;
            threshold_model[c] = '0;
        end
        repeat (RESET_CYCLES) @(negedge CLOCK_50);
        KEY0 = 1'b1;
        @(negedge CLOCK_50);
        check_value("ack (after reset)", '0, data_t'(ack));
        check_irq_lines();
        check_plic_state();

        // ram starts unknown, give every word a defined value
        for (int i = 0; i < FILL_OPS; i++) begin
            ram_op(1'b1, ld, 2 * i, 2'b00, {fill_word(2 * i + 1), fill_word(2 * i)});
        end
        repeat (RANDOM_OPS) random_ram_op();
        repeat (DWORD_ROUNDS) dword_round();
        repeat (UNMAPPED_ROUNDS) unmapped_round();
        repeat (REG_ROUNDS) register_round();
        // out-of-range priority writes must not land in another register
        check_plic_state();
        repeat (IRQ_ROUNDS) irq_round();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
soc_bus_pkg.sv
bus_decode_stage.sv
ram_target.sv
plic_target.sv
bus_response_stage.sv
soc_bus_top.sv
tb_soc_bus.sv
